// ==== usb_buf_pkg.sv ====
// usb endpoint buffer shared definitions
// buffer sizing, ahb register map and the structs passed between blocks
`default_nettype none

package usb_buf_pkg;

  // ****************************************
  // buffer sizing
  // ****************************************
  localparam int buf_depth = 64;  // bytes held by the endpoint buffer
  localparam int occ_width = 7;   // 0..64 needs 7 bits

  // register offsets, byte addressed
  localparam logic [3:0] reg_data   = 4'h0;  // fifo data window
  localparam logic [3:0] reg_status = 4'h4;  // occupancy in 6:0
  localparam logic [3:0] reg_ctrl   = 4'h8;  // bit 0 clear, bit 1 reserve

  // ahb-lite encodings
  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;
  localparam logic       hresp_okay    = 1'b0;
  localparam logic       hresp_error   = 1'b1;

  // ****************************************
  // bus structs
  // ****************************************
  typedef struct packed {
    logic        hsel;
    logic [3:0]  haddr;   // only the register offset is decoded
    logic [1:0]  htrans;
    logic        hwrite;
    logic [2:0]  hsize;   // bytes minus one on the data register
    logic [31:0] hwdata;  // data phase
  } ahb_req_t;

  typedef struct packed {
    logic [31:0] hrdata;
    logic        hready;
    logic        hresp;
  } ahb_rsp_t;

  // slave to buffer requests
  typedef struct packed {
    logic        get_rx_data;      // pop data_size+1 bytes for the host
    logic        store_tx_data;    // push data_size+1 bytes of tx_data
    logic [1:0]  data_size;        // bytes minus one
    logic [31:0] tx_data;          // lsb first
    logic        clear;            // empty the buffer
    logic        buffer_reserved;  // host owns buffer, usb rx pushes dropped
  } buf_req_t;

endpackage

`default_nettype wire

// ==== data_buffer.sv ====
// data_buffer
// 64 byte circular fifo, byte push/pop on the usb side and
// 1 to 4 byte push/pop on the host side, with occupancy count
`timescale 1ns/10ps
`default_nettype none

module data_buffer (
  input  wire logic                                tb_clk,
  input  wire logic                                reset,
  input  wire usb_buf_pkg::buf_req_t               req,
  input  wire logic                                store_rx_packet_data,
  input  wire logic [7:0]                          rx_packet_data,
  input  wire logic                                get_tx_packet_data,
  output logic      [31:0]                         rx_data,
  output logic      [7:0]                          tx_packet_data,
  output logic      [usb_buf_pkg::occ_width-1:0]   buffer_occupancy
);

  // ****************************************
  // storage and pointers
  // ****************************************
  logic [7:0] mem [usb_buf_pkg::buf_depth];  // byte array
  logic [5:0] rd_ptr;                        // head, oldest byte
  logic [5:0] wr_ptr;                        // next free slot
  logic [usb_buf_pkg::occ_width-1:0] count;  // bytes held

  logic        usb_push;   // rx byte push that is not blocked
  logic [2:0]  push_n;     // bytes written this cycle, 0..4
  logic [2:0]  rx_pop_n;   // bytes the host pops, 0..4
  logic [2:0]  pop_n;      // host pop plus usb pop, 0..5
  logic [31:0] push_word;  // byte lanes to be written, lane 0 at wr_ptr

  // ****************************************
  // push / pop sizing
  // ****************************************
  // rx bytes are dropped while the host holds the buffer for transmit
  assign usb_push = store_rx_packet_data && !req.buffer_reserved;

  always_comb begin
    if (req.store_tx_data) begin
      push_n    = {1'b0, req.data_size} + 3'd1;  // 1..4 bytes
      push_word = req.tx_data;
    end else if (usb_push) begin
      push_n    = 3'd1;
      push_word = {24'h0, rx_packet_data};      // single byte in lane 0
    end else begin
      push_n    = 3'd0;
      push_word = req.tx_data;                  // don't care, nothing written
    end
  end

  assign rx_pop_n = req.get_rx_data ? {1'b0, req.data_size} + 3'd1 : 3'd0;
  assign pop_n    = rx_pop_n + {2'b00, get_tx_packet_data};  // both counted together

  // ****************************************
  // byte array writes
  // ****************************************
  always_ff @(posedge tb_clk) begin
    for (int i = 0; i < 4; i++) begin
      if (i < push_n && !req.clear) begin
        mem[wr_ptr + 6'(i)] <= push_word[8*i +: 8];  // pointer wraps at 64
      end
    end
  end

  // pointers and count, clear wins over any push or pop
  always_ff @(posedge tb_clk) begin
    if (reset || req.clear) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      rd_ptr <= rd_ptr + pop_n;
      wr_ptr <= wr_ptr + push_n;
      count  <= count + push_n - pop_n;  // net change, widths extend to 7 bits
    end
  end

  assign buffer_occupancy = count;  // visible one clock after the update

  // ****************************************
  // read side
  // ****************************************
  // head bytes, masked above data_size+1 so unused lanes read zero
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (i <= req.data_size) begin
        rx_data[8*i +: 8] = mem[rd_ptr + 6'(i)];
      end else begin
        rx_data[8*i +: 8] = 8'h00;
      end
    end
  end

  // usb tx byte, held from the clock after the pop strobe
  // a host pop in the same cycle takes the bytes ahead of it
  always_ff @(posedge tb_clk) begin
    if (get_tx_packet_data) begin
      tx_packet_data <= mem[rd_ptr + rx_pop_n];
    end
  end

  // ****************************************
  // checks
  // ****************************************
  // usb side has no back-pressure, so catch misuse from either side here
  a_no_underflow : assert property (@(posedge tb_clk) disable iff (reset)
    !req.clear |-> pop_n <= count)
    else $error("pop of %0d bytes with only %0d held", pop_n, count);

  a_no_overflow : assert property (@(posedge tb_clk) disable iff (reset)
    !req.clear |-> (count + push_n) <= usb_buf_pkg::buf_depth)
    else $error("push of %0d bytes with %0d already held", push_n, count);

  a_single_pusher : assert property (@(posedge tb_clk) disable iff (reset)
    !(usb_push && req.store_tx_data))
    else $error("usb rx push and host push in the same cycle");

  // count must stay in range across any mix of pushes, pops and clears
  a_occ_range : assert property (@(posedge tb_clk) disable iff (reset)
    count <= usb_buf_pkg::buf_depth)
    else $error("occupancy %0d beyond buffer depth", count);

endmodule

`default_nettype wire

// ==== ahb_buffer_slave.sv ====
// ahb_buffer_slave
// ahb-lite register slave for the endpoint buffer: data, status and
// control registers, with a two cycle error for over-read or over-fill
`timescale 1ns/10ps
`default_nettype none

module ahb_buffer_slave (
  input  wire logic                                tb_clk,
  input  wire logic                                reset,
  input  wire usb_buf_pkg::ahb_req_t               ahb_req,
  input  wire logic [31:0]                         rx_data,
  input  wire logic [usb_buf_pkg::occ_width-1:0]   buffer_occupancy,
  output usb_buf_pkg::ahb_rsp_t                    ahb_rsp,
  output usb_buf_pkg::buf_req_t                    req
);

  // ****************************************
  // address phase capture
  // ****************************************
  logic       addr_accept;  // nonseq transfer sampled this cycle
  logic       dp_valid;     // a transfer is in its data phase
  logic       dp_write;
  logic [3:0] dp_addr;
  logic [1:0] dp_size;      // bytes minus one
  logic       err_hold;     // second cycle of an error response
  logic       reserved;     // buffer_reserved, held until next ctrl write

  logic dp_data;
  logic dp_status;
  logic dp_ctrl;
  logic ctrl_wr;
  logic rd_err;
  logic wr_err;
  logic err_now;            // first error cycle, hready low
  logic [usb_buf_pkg::occ_width-1:0] need_n;  // bytes asked for, 1..4

  assign addr_accept = ahb_req.hsel && (ahb_req.htrans == usb_buf_pkg::htrans_nonseq)
                       && ahb_rsp.hready;

  always_ff @(posedge tb_clk) begin
    if (reset) begin
      dp_valid <= 1'b0;
      err_hold <= 1'b0;
      reserved <= 1'b0;
    end else begin
      err_hold <= err_now;
      if (ahb_rsp.hready) begin
        dp_valid <= addr_accept;
      end else begin
        dp_valid <= 1'b0;  // failed transfer ends, buffer untouched
      end
      if (ctrl_wr) begin
        reserved <= ahb_req.hwdata[1];  // bit 1 follows every ctrl write
      end
    end
  end

  // address phase payload, only looked at while dp_valid
  always_ff @(posedge tb_clk) begin
    if (addr_accept) begin
      dp_write <= ahb_req.hwrite;
      dp_addr  <= ahb_req.haddr;
      dp_size  <= ahb_req.hsize[1:0];
    end
  end

  // ****************************************
  // data phase decode
  // ****************************************
  assign dp_data   = dp_valid && (dp_addr == usb_buf_pkg::reg_data);
  assign dp_status = dp_valid && (dp_addr == usb_buf_pkg::reg_status);
  assign dp_ctrl   = dp_valid && (dp_addr == usb_buf_pkg::reg_ctrl);
  assign ctrl_wr   = dp_ctrl && dp_write;

  assign need_n = dp_size + 1'b1;  // extends to 7 bits before the add

  // occupancy already reflects the previous transfer here
  assign rd_err  = dp_data && !dp_write && (need_n > buffer_occupancy);
  assign wr_err  = dp_data && dp_write &&
                   ((buffer_occupancy + need_n) > usb_buf_pkg::buf_depth);
  assign err_now = rd_err || wr_err;

  // ****************************************
  // bus response
  // ****************************************
  always_comb begin
    ahb_rsp.hready = !err_now;  // low only in the first error cycle
    ahb_rsp.hresp  = (err_now || err_hold) ? usb_buf_pkg::hresp_error
                                           : usb_buf_pkg::hresp_okay;
    ahb_rsp.hrdata = 32'h0;
    if (dp_data && !dp_write && !rd_err) begin
      ahb_rsp.hrdata = rx_data;  // head bytes, already masked by size
    end else if (dp_status && !dp_write) begin
      ahb_rsp.hrdata = 32'(buffer_occupancy);  // count in 6:0
    end
  end

  // buffer requests, issued in the data phase
  always_comb begin
    req.get_rx_data     = dp_data && !dp_write && !rd_err;  // pop with hrdata
    req.store_tx_data   = dp_data && dp_write && !wr_err;
    req.data_size       = dp_size;
    req.tx_data         = ahb_req.hwdata;                   // valid in data phase
    req.clear           = ctrl_wr && ahb_req.hwdata[0];     // one cycle pulse
    req.buffer_reserved = reserved;
  end

  // error response always finishes on its second cycle
  a_hready_recovers : assert property (@(posedge tb_clk) disable iff (reset)
    !ahb_rsp.hready |=> ahb_rsp.hready)
    else $error("hready low for two cycles in a row");

endmodule

`default_nettype wire

// ==== usb_endpoint_buffer.sv ====
// usb_endpoint_buffer
// top level: ahb-lite slave in front of the 64 byte endpoint buffer
`timescale 1ns/10ps
`default_nettype none

module usb_endpoint_buffer (
  input  wire logic                                tb_clk,
  input  wire logic                                reset,
  // ****************************************
  // ahb-lite side
  // ****************************************
  input  wire usb_buf_pkg::ahb_req_t               ahb_req,
  output usb_buf_pkg::ahb_rsp_t                    ahb_rsp,
  // ****************************************
  // usb byte side
  // ****************************************
  input  wire logic                                store_rx_packet_data,  // rx push strobe
  input  wire logic [7:0]                          rx_packet_data,
  input  wire logic                                get_tx_packet_data,    // tx pop strobe
  output logic      [7:0]                          tx_packet_data,        // registered
  output logic      [usb_buf_pkg::occ_width-1:0]   buffer_occupancy
);

  usb_buf_pkg::buf_req_t buf_req;  // slave to buffer
  logic [31:0]           rx_data;  // head bytes back to the slave

  ahb_buffer_slave u_slave (
    .tb_clk           (tb_clk),
    .reset            (reset),
    .ahb_req          (ahb_req),
    .rx_data          (rx_data),
    .buffer_occupancy (buffer_occupancy),
    .ahb_rsp          (ahb_rsp),
    .req              (buf_req)
  );

  data_buffer u_buffer (
    .tb_clk               (tb_clk),
    .reset                (reset),
    .req                  (buf_req),
    .store_rx_packet_data (store_rx_packet_data),
    .rx_packet_data       (rx_packet_data),
    .get_tx_packet_data   (get_tx_packet_data),
    .rx_data              (rx_data),
    .tx_packet_data       (tx_packet_data),
    .buffer_occupancy     (buffer_occupancy)  // also read by the slave
  );

endmodule

`default_nettype wire

// ==== tb_usb_endpoint_buffer.sv ====
// tb_usb_endpoint_buffer
// self-checking testbench that builds a step table from a byte queue model and replays it
`timescale 1ns/10ps
`default_nettype none

module tb_usb_endpoint_buffer;

  typedef enum logic [2:0] {
    op_usb_push, op_usb_pop, op_bus_read, op_bus_write, op_status, op_ctrl
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [1:0]  size;     // bytes minus one
    logic [31:0] data;     // push byte, write word or ctrl value
    logic [31:0] exp_val;  // expected read data, pop byte or count
    logic        exp_err;  // expected ERROR response
  } step_t;

  logic                  tb_clk;
  logic                  reset;
  usb_buf_pkg::ahb_req_t ahb_req;
  usb_buf_pkg::ahb_rsp_t ahb_rsp;
  logic                  store_rx_packet_data;
  logic [7:0]            rx_packet_data;
  logic                  get_tx_packet_data;
  logic [7:0]            tx_packet_data;
  logic [usb_buf_pkg::occ_width-1:0] buffer_occupancy;

  step_t      tbl[$];       // stimulus and expected values
  logic [7:0] model_q[$];   // reference byte fifo
  logic       reserved_m;   // model copy of the reserve bit
  logic [31:0] lfsr = 32'h0c7d_584b;
  logic       tbl_ready = 1'b0;
  int         errors = 0;
  int         checks = 0;

  usb_endpoint_buffer UUT (
    .tb_clk (tb_clk), .reset (reset), .ahb_req (ahb_req), .ahb_rsp (ahb_rsp),
    .store_rx_packet_data (store_rx_packet_data), .rx_packet_data (rx_packet_data),
    .get_tx_packet_data (get_tx_packet_data), .tx_packet_data (tx_packet_data),
    .buffer_occupancy (buffer_occupancy)
  );

  initial begin
    tb_clk = 1'b0;
    forever #50 tb_clk = ~tb_clk;  // 100 ns period
  end

  // ****************************************
  // stimulus source and reference model
  // ****************************************
  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // append a step whose expected result comes from the model queue
  function automatic void add_step(input op_e op, input logic [1:0] size,
                                   input logic [31:0] data);
    step_t s;
    int    n;
    s = '{op: op, size: size, data: data, exp_val: 32'h0, exp_err: 1'b0};
    n = int'(size) + 1;
    case (op)
      op_usb_push: if (!reserved_m) model_q.push_back(data[7:0]);  // dropped while reserved
      op_usb_pop: s.exp_val = {24'h0, model_q.pop_front()};
      op_bus_read: begin
        if (n > model_q.size()) begin
          s.exp_err = 1'b1;  // over-read leaves the queue untouched
        end else begin
          for (int i = 0; i < n; i++) s.exp_val[8*i +: 8] = model_q.pop_front();
        end
      end
      op_bus_write: begin
        if (model_q.size() + n > usb_buf_pkg::buf_depth) begin
          s.exp_err = 1'b1;  // over-fill
        end else begin
          for (int i = 0; i < n; i++) model_q.push_back(data[8*i +: 8]);
        end
      end
      op_status: s.exp_val = 32'(model_q.size());
      default: begin     // ctrl write
        if (data[0]) model_q.delete();
        reserved_m = data[1];
      end
    endcase
    tbl.push_back(s);
  endfunction

  function automatic void build_table();
    reserved_m = 1'b0;
    repeat (7) add_step(op_usb_push, 2'd0, lfsr_bits(8));  // usb bytes out over the bus
    add_step(op_status, 2'd2, 32'h0);
    add_step(op_bus_read, 2'd0, 32'h0);
    add_step(op_bus_read, 2'd1, 32'h0);
    add_step(op_bus_read, 2'd3, 32'h0);
    add_step(op_status, 2'd2, 32'h0);
    for (int k = 0; k < 4; k++) add_step(op_bus_write, 2'(k), lfsr_bits(32));  // 1..4 bytes
    add_step(op_status, 2'd2, 32'h0);
    repeat (10) add_step(op_usb_pop, 2'd0, 32'h0);
    add_step(op_status, 2'd2, 32'h0);
    repeat (32) add_step(op_usb_push, 2'd0, lfsr_bits(8));  // full fill with half from usb
    add_step(op_status, 2'd2, 32'h0);
    repeat (8) add_step(op_bus_write, 2'd3, lfsr_bits(32));
    add_step(op_status, 2'd2, 32'h0);                          // 64
    add_step(op_bus_write, 2'd0, lfsr_bits(32));               // one byte too many
    add_step(op_status, 2'd2, 32'h0);
    repeat (16) add_step(op_bus_read, 2'd3, 32'h0);            // drain
    add_step(op_status, 2'd2, 32'h0);
    add_step(op_usb_push, 2'd0, lfsr_bits(8));
    add_step(op_bus_read, 2'd1, 32'h0);                        // 2 asked with 1 held
    add_step(op_status, 2'd2, 32'h0);
    // clear and then reserve for transmit
    add_step(op_bus_write, 2'd3, lfsr_bits(32));
    add_step(op_status, 2'd2, 32'h0);
    add_step(op_ctrl, 2'd2, 32'h1);
    add_step(op_status, 2'd2, 32'h0);
    add_step(op_ctrl, 2'd2, 32'h2);
    repeat (3) add_step(op_usb_push, 2'd0, lfsr_bits(8));   // ignored
    add_step(op_status, 2'd2, 32'h0);
    add_step(op_bus_write, 2'd3, lfsr_bits(32));
    add_step(op_status, 2'd2, 32'h0);
    repeat (4) add_step(op_usb_pop, 2'd0, 32'h0);
    add_step(op_ctrl, 2'd2, 32'h0);                            // release
    add_step(op_usb_push, 2'd0, lfsr_bits(8));
    add_step(op_status, 2'd2, 32'h0);
    add_step(op_bus_read, 2'd0, 32'h0);
  endfunction

  // ****************************************
  // bus and usb drivers
  // ****************************************
  task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                             input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Fail %0d ns: %s, got %h expected %h", $time, what, got, want);
    end
  endtask

  // one ahb-lite transfer that waits for hready in the data phase
  task automatic bus_xfer(input logic write, input logic [3:0] addr, input logic [1:0] size,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic resp, output int waits);  // waits counts hready low
    @(negedge tb_clk);
    ahb_req.hsel   = 1'b1;  // address phase
    ahb_req.htrans = usb_buf_pkg::htrans_nonseq;
    ahb_req.haddr  = addr;
    ahb_req.hwrite = write;
    ahb_req.hsize  = {1'b0, size};
    @(negedge tb_clk);
    ahb_req.hsel   = 1'b0;
    ahb_req.htrans = usb_buf_pkg::htrans_idle;
    ahb_req.hwdata = wdata;  // data phase
    #10;
    waits = 0;
    while (!ahb_rsp.hready && waits < 4) begin
      @(negedge tb_clk);
      #10;
      waits++;
    end
    if (!ahb_rsp.hready) begin
      errors++;
      $display("bus transfer at %0d ns never saw hready go high", $time);
    end
    rdata = ahb_rsp.hrdata;
    resp  = ahb_rsp.hresp;
  endtask

  task automatic apply_step(input step_t s, input int idx);
    logic [31:0] rdata;
    logic        resp;
    int          waits;
    case (s.op)
      op_usb_push: begin
        @(negedge tb_clk);
        store_rx_packet_data = 1'b1;
        rx_packet_data       = s.data[7:0];
        @(negedge tb_clk);
        store_rx_packet_data = 1'b0;
      end
      op_usb_pop: begin
        @(negedge tb_clk);
        get_tx_packet_data = 1'b1;
        @(negedge tb_clk);
        get_tx_packet_data = 1'b0;  // byte registered on the clock just passed
        check_value({24'h0, tx_packet_data}, s.exp_val, $sformatf("step %0d usb pop", idx));
      end
      op_status: begin
        bus_xfer(1'b0, usb_buf_pkg::reg_status, s.size, 32'h0, rdata, resp, waits);
        check_value(32'(resp), 32'(usb_buf_pkg::hresp_okay),
                    $sformatf("step %0d status resp", idx));
        check_value(32'(waits), 32'd0, $sformatf("step %0d status wait cycles", idx));
        check_value(rdata, s.exp_val, $sformatf("step %0d status count", idx));
        check_value(32'(buffer_occupancy), s.exp_val,
                    $sformatf("step %0d occupancy port", idx));
      end
      default: begin  // data read, data write, ctrl write
        bus_xfer(s.op != op_bus_read, (s.op == op_ctrl) ? usb_buf_pkg::reg_ctrl
                 : usb_buf_pkg::reg_data, s.size, s.data, rdata, resp, waits);
        check_value(32'(resp), 32'(s.exp_err), $sformatf("step %0d bus resp", idx));
        check_value(32'(waits), s.exp_err ? 32'd1 : 32'd0,
                    $sformatf("step %0d bus wait cycles", idx));  // error holds hready low once
        if (s.op == op_bus_read && !s.exp_err) begin
          check_value(rdata, s.exp_val, $sformatf("step %0d data read", idx));
        end
      end
    endcase
  endtask

  // ****************************************
  // main sequence and watchdog
  // ****************************************
  initial begin
    reset = 1'b1;
    ahb_req = '0;
    store_rx_packet_data = 1'b0;
    rx_packet_data = 8'h00;
    get_tx_packet_data = 1'b0;
    build_table();
    tbl_ready = 1'b1;
    repeat (8) @(posedge tb_clk);
    @(negedge tb_clk);
    reset = 1'b0;
    foreach (tbl[i]) apply_step(tbl[i], i);
    $display("steps: %0d, checks: %0d, errors: %0d", tbl.size(), checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    wait (tbl_ready);
    repeat (tbl.size() * 10) @(posedge tb_clk);  // ten clocks per step
    $display("watchdog expired before the step table finished");
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== usb_endpoint_buffer.f ====
usb_buf_pkg.sv
data_buffer.sv
ahb_buffer_slave.sv
usb_endpoint_buffer.sv
tb_usb_endpoint_buffer.sv

// ==== Makefile ====
# verilator build and run for usb_endpoint_buffer
TOP := tb_usb_endpoint_buffer

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f usb_endpoint_buffer.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "No errors" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module usb_endpoint_buffer \
		usb_buf_pkg.sv data_buffer.sv ahb_buffer_slave.sv usb_endpoint_buffer.sv

clean:
	rm -rf obj_dir sim.log
